// ==== bench/pruneTb.sv ====
module pruneTb import leafPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod = 8;
    localparam int directedCount = 4;
    localparam int randomCount = 40;
    localparam int testCount = directedCount + randomCount;
    localparam int cyclesPerGraph = 270;
    localparam int cycleLimit = testCount * cyclesPerGraph + 200;
    localparam logic [15:0] lfsrSeed = 16'd58441;

    logic                  clk;
    logic                  rstN;
    logic                  inValid;
    logic                  inReady;
    logic [graphWidth-1:0] inGraph;
    logic                  outValid;
    logic                  outReady;
    logic [graphWidth-1:0] outGraph;
    logic [countWidth-1:0] outCount;
    logic [roundWidth-1:0] outRounds;

    logic [15:0]           lfsrState;
    logic [graphWidth-1:0] nextGraph;
    logic                  accepted;
    logic                  stallA;
    logic                  stallB;
    logic                  gapA;
    logic                  gapB;
    int                    sent;
    int                    received;
    int                    gapLeft;
    int                    endErrors;
    int                    cycleCount = 0;

    pruneTop u_dut (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inReady(inReady),
        .inGraph(inGraph),
        .outValid(outValid),
        .outReady(outReady),
        .outGraph(outGraph),
        .outCount(outCount),
        .outRounds(outRounds)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////
    // Random source
    ////////////////////////////////

    // 16-bit Fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeBit(output logic b);
        b = lfsrState[15];
        lfsrState = lfsrNext(lfsrState);
    endtask

    // Directed graphs first, then random ones, every other one sparse
    task automatic buildGraph(input int index, output logic [graphWidth-1:0] g);
        logic b1;
        logic b2;
        g = '0;
        case (index)
            0: g = '1;
            1: begin
                g[0] = 1'b1;
                g[graphWidth-1] = 1'b1;
            end
            2: begin
                // Chain 0 1 3 ... 127 with a tail from the top peeling one node a round
                for (int k = 0; k <= latticeDim; k++) begin
                    g[(1 << k) - 1] = 1'b1;
                end
                for (int k = 1; k <= 5; k++) begin
                    g[graphWidth - (1 << k)] = 1'b1;
                end
            end
            3: begin
                g[0] = 1'b1;
                g[21] = 1'b1;
                g[42] = 1'b1;
                g[105] = 1'b1;
                g[graphWidth-1] = 1'b1;
            end
            default: begin
                for (int i = 0; i < graphWidth; i++) begin
                    takeBit(b1);
                    if (index % 2 == 1) begin
                        takeBit(b2);
                        g[i] = b1 & b2;
                    end else begin
                        g[i] = b1;
                    end
                end
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run passed %0d cycles with %0d of %0d results taken",
                     cycleLimit, received, testCount);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////

    initial begin
        rstN = 1'b0;
        inValid = 1'b0;
        inGraph = '0;
        outReady = 1'b0;
        lfsrState = lfsrSeed;
        sent = 0;
        received = 0;
        gapLeft = 0;
        endErrors = 0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        outReady = 1'b1;
        while (received < testCount) begin
            @(posedge clk);
            accepted = inValid && inReady;
            if (accepted) begin
                sent++;
            end
            if (outValid && outReady) begin
                received++;
            end
            #1;
            // Stall the consumer a quarter of the time
            takeBit(stallA);
            takeBit(stallB);
            outReady = stallA | stallB;
            if (accepted) begin
                inValid = 1'b0;
                takeBit(gapA);
                takeBit(gapB);
                gapLeft = {gapA, gapB};
            end
            if (!inValid && sent < testCount) begin
                if (gapLeft > 0) begin
                    gapLeft--;
                end else begin
                    buildGraph(sent, nextGraph);
                    inGraph = nextGraph;
                    inValid = 1'b1;
                end
            end
        end
        repeat (4) @(posedge clk);
        assert (u_dut.checks.pending == 0) else begin
            endErrors++;
            $error("Accepted graphs never came out: %0d pending", u_dut.checks.pending);
        end
        $display("Closing: %0d sent, %0d taken, %0d assertion failures, %0d end failures",
                 sent, received, u_dut.checks.failCount, endErrors);
        if (u_dut.checks.failCount == 0 && endErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/prune_assertions.sv ====
module prune_assertions import leafPkg::*; (
    input logic                  clk,
    input logic                  rstN,
    input logic                  inValid,
    input logic                  inReady,
    input logic [graphWidth-1:0] inGraph,
    input logic                  outValid,
    input logic                  outReady,
    input logic [graphWidth-1:0] outGraph,
    input logic [countWidth-1:0] outCount,
    input logic [roundWidth-1:0] outRounds,
    input logic                  linkValid,
    input logic                  linkReady
);

    timeunit 1ns;
    timeprecision 1ps;

    // At most one graph in the engine and two in the counter
    localparam int depth = 8;

    logic [graphWidth-1:0] srcMem [depth];
    logic [graphWidth-1:0] expMem [depth];
    logic [roundWidth-1:0] roundMem [depth];
    logic [2:0]            wrPtr;
    logic [2:0]            rdPtr;
    logic [3:0]            pending;
    logic                  engineBusy;
    logic                  inFire;
    logic                  outFire;
    logic                  linkFire;
    logic [graphWidth-1:0] refGraph;
    logic [roundWidth-1:0] refRounds;
    logic [graphWidth-1:0] frontSrc;
    logic [graphWidth-1:0] frontGraph;
    logic [roundWidth-1:0] frontRounds;
    logic [countWidth-1:0] outPop;
    int                    failCount = 0;

    ////////////////////////////////
    // Reference pruning model
    ////////////////////////////////

    // One elimination step, neighbours counted on the old graph
    function automatic logic [graphWidth-1:0] stepOnce(input logic [graphWidth-1:0] g,
                                                       input bit upward);
        logic [graphWidth-1:0] r;
        int higher;
        int lower;
        r = g;
        for (int n = 1; n < graphWidth - 1; n++) begin
            higher = 0;
            lower = 0;
            for (int b = 0; b < latticeDim; b++) begin
                if (n[b]) begin
                    lower += g[n ^ (1 << b)];
                end else begin
                    higher += g[n ^ (1 << b)];
                end
            end
            if (!upward && higher == 1 && lower == 0) begin
                r[n] = 1'b0;
            end
            if (upward && lower == 1 && higher == 0) begin
                r[n] = 1'b0;
            end
        end
        return r;
    endfunction

    // Rounds of down then up until a round leaves the graph alone
    function automatic void settle(input logic [graphWidth-1:0] g,
                                   output logic [graphWidth-1:0] fixedGraph,
                                   output logic [roundWidth-1:0] rounds);
        logic [graphWidth-1:0] cur;
        logic [graphWidth-1:0] nxt;
        int count;
        bit changed;
        cur = g;
        count = 0;
        do begin
            nxt = stepOnce(stepOnce(cur, 1'b0), 1'b1);
            count++;
            changed = (nxt != cur);
            cur = nxt;
        end while (changed && count < maxRounds);
        fixedGraph = cur;
        rounds = roundWidth'(count);
    endfunction

    always_comb begin
        settle(inGraph, refGraph, refRounds);
    end

    ////////////////////////////////
    // Pending results
    ////////////////////////////////

    assign inFire = inValid && inReady;
    assign outFire = outValid && outReady;
    assign linkFire = linkValid && linkReady;
    assign frontSrc = srcMem[rdPtr];
    assign frontGraph = expMem[rdPtr];
    assign frontRounds = roundMem[rdPtr];
    assign outPop = countWidth'($countones(outGraph));

    always_ff @(posedge clk) begin
        if (inFire) begin
            srcMem[wrPtr] <= inGraph;
            expMem[wrPtr] <= refGraph;
            roundMem[wrPtr] <= refRounds;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            pending <= '0;
            engineBusy <= 1'b0;
        end else begin
            wrPtr <= wrPtr + 3'(inFire);
            rdPtr <= rdPtr + 3'(outFire);
            pending <= pending + 4'(inFire) - 4'(outFire);
            // Engine holds a graph until the counter takes it
            if (linkFire) begin
                engineBusy <= 1'b0;
            end else if (inFire) begin
                engineBusy <= 1'b1;
            end
        end
    end

    ////////////////////////////////
    // Properties
    ////////////////////////////////

    resultGraph: assert property (@(posedge clk) disable iff (!rstN)
        outFire |-> outGraph == frontGraph)
        else begin
            failCount++;
            $error("** Error pruned graph: expected %h actual %h",
                   $sampled(frontGraph), $sampled(outGraph));
        end

    resultRounds: assert property (@(posedge clk) disable iff (!rstN)
        outFire |-> outRounds == frontRounds)
        else begin
            failCount++;
            $error("** Error round count: expected %0d actual %0d",
                   $sampled(frontRounds), $sampled(outRounds));
        end

    nodeCount: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> outCount == outPop)
        else begin
            failCount++;
            $error("** Error node count: expected %0d actual %0d",
                   $sampled(outPop), $sampled(outCount));
        end

    // Nothing appears, and bottom and top pass through
    latticeInvariant: assert property (@(posedge clk) disable iff (!rstN)
        outFire |-> ((outGraph & ~frontSrc) == '0) && (outGraph[0] == frontSrc[0]) &&
                    (outGraph[graphWidth-1] == frontSrc[graphWidth-1]))
        else begin
            failCount++;
            $error("** Error lattice invariant: expected subset of %h actual %h",
                   $sampled(frontSrc), $sampled(outGraph));
        end

    noExtraResult: assert property (@(posedge clk) disable iff (!rstN)
        outFire |-> pending != '0)
        else begin
            failCount++;
            $error("A result left the design with no accepted graph pending");
        end

    noPileUp: assert property (@(posedge clk) disable iff (!rstN)
        pending <= 4'd3)
        else begin
            failCount++;
            $error("More graphs pending than the design can hold");
        end

    holdStable: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=>
            outValid && $stable(outGraph) && $stable(outCount) && $stable(outRounds))
        else begin
            failCount++;
            $error("Output changed or dropped while the consumer stalled");
        end

    resetState: assert property (@(posedge clk)
        !rstN |=> !outValid && inReady && !linkValid)
        else begin
            failCount++;
            $error("Outputs not in their idle state after reset");
        end

    engineBusyLow: assert property (@(posedge clk) disable iff (!rstN)
        engineBusy |-> !inReady)
        else begin
            failCount++;
            $error("Input ready while the engine still holds a graph");
        end

endmodule

bind pruneTop prune_assertions checks (
    .clk(clk),
    .rstN(rstN),
    .inValid(inValid),
    .inReady(inReady),
    .inGraph(inGraph),
    .outValid(outValid),
    .outReady(outReady),
    .outGraph(outGraph),
    .outCount(outCount),
    .outRounds(outRounds),
    .linkValid(link.valid),
    .linkReady(link.ready)
);

// ==== logic/graphBus.sv ====
interface graphBus import leafPkg::*; ();

    // Handshake
    logic valid;
    logic ready;

    // Payload, held by the source while valid is high and ready is low
    logic [graphWidth-1:0] graph;
    logic [roundWidth-1:0] rounds;

    // Engine side
    modport source (
        output valid,
        output graph,
        output rounds,
        input  ready
    );

    // Counter side
    modport sink (
        input  valid,
        input  graph,
        input  rounds,
        output ready
    );

endinterface

// ==== logic/leafElimination.sv ====
module leafElimination import leafPkg::*; #(
    parameter int direction = directionDown
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  clkEn,
    input  logic [graphWidth-1:0] graphIn,
    output logic [graphWidth-1:0] graphOut
);

    ////////////////////////////////
    // Elaboration helpers
    ////////////////////////////////

    // Number of set index bits, which is the node's level in the lattice
    function automatic int bitCount(int value);
        int total;
        total = 0;
        for (int i = 0; i < latticeDim; i++) begin
            total += (value >> i) & 1;
        end
        return total;
    endfunction

    // Position of the n-th index bit equal to level
    function automatic int nthBitIndex(int value, int n, int level);
        int seen;
        int index;
        seen = 0;
        index = 0;
        for (int i = 0; i < latticeDim; i++) begin
            if (((value >> i) & 1) == level) begin
                if (seen == n) begin
                    index = i;
                end
                seen++;
            end
        end
        return index;
    endfunction

    logic [graphWidth-1:0] graphNext;

    // Bottom and top are never removed
    assign graphNext[0] = graphIn[0];
    assign graphNext[graphWidth-1] = graphIn[graphWidth-1];

    ////////////////////////////////
    // Per-node rule
    ////////////////////////////////

    for (genvar node = 1; node < graphWidth - 1; node++) begin : gNode
        logic [bitCount(node)-1:0] below;
        logic [latticeDim-bitCount(node)-1:0] above;
        logic single;
        logic none;

        // Clear one set bit to reach a node one level down
        for (genvar k = 0; k < bitCount(node); k++) begin : gBelow
            assign below[k] = graphIn[node & ~(1 << nthBitIndex(node, k, 1))];
        end

        // Set one clear bit to reach a node one level up
        for (genvar k = 0; k < latticeDim - bitCount(node); k++) begin : gAbove
            assign above[k] = graphIn[node | (1 << nthBitIndex(node, k, 0))];
        end

        if (direction == directionDown) begin : gDown
            // Leaf hanging from a single parent, nothing beneath
            assign single = (above != '0) && ((above & (above - 1'b1)) == '0);
            assign none = (below == '0);
        end else begin : gUp
            // Mirror case, single child and nothing above
            assign single = (below != '0) && ((below & (below - 1'b1)) == '0);
            assign none = (above == '0);
        end

        assign graphNext[node] = graphIn[node] & ~(single & none);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            graphOut <= '0;
        end else if (clkEn) begin
            graphOut <= graphNext;
        end
    end

endmodule

// ==== logic/leafPkg.sv ====
package leafPkg;

    ////////////////////////////////
    // Lattice geometry
    ////////////////////////////////

    // Index bits per node
    localparam int latticeDim = 7;

    // One bit per lattice node, 0 is bottom and 127 is top
    localparam int graphWidth = 1 << latticeDim;

    ////////////////////////////////
    // Result widths
    ////////////////////////////////

    // Holds 0 to 128 nodes
    localparam int countWidth = 8;

    // Round counter width
    localparam int roundWidth = 8;

    // Safety limit, a real graph converges well before this
    localparam int maxRounds = 128;

    // Popcount slices for the node counter
    localparam int sliceWidth = 16;
    localparam int sliceCount = graphWidth / sliceWidth;
    localparam int partialWidth = 5;

    ////////////////////////////////
    // Elimination direction
    ////////////////////////////////

    localparam int directionDown = 0;
    localparam int directionUp = 1;

endpackage

// ==== logic/nodeCounter.sv ====
module nodeCounter import leafPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    graphBus.sink                 bus,
    output logic                  outValid,
    input  logic                  outReady,
    output logic [graphWidth-1:0] outGraph,
    output logic [countWidth-1:0] outCount,
    output logic [roundWidth-1:0] outRounds
);

    logic                    s1Valid;
    logic [graphWidth-1:0]   s1Graph;
    logic [roundWidth-1:0]   s1Rounds;
    logic [partialWidth-1:0] s1Partial [sliceCount];
    logic [partialWidth-1:0] partialNext [sliceCount];
    logic [countWidth-1:0]   countNext;
    logic                    s2Free;
    logic                    busFire;

    // Output stage empty or handing off this cycle
    assign s2Free = !outValid || outReady;
    assign bus.ready = s2Free;
    assign busFire = bus.valid && bus.ready;

    ////////////////////////////////
    // Stage one, slice popcounts
    ////////////////////////////////

    always_comb begin
        for (int s = 0; s < sliceCount; s++) begin
            partialNext[s] = '0;
            for (int b = 0; b < sliceWidth; b++) begin
                partialNext[s] = partialNext[s] + partialWidth'(bus.graph[s*sliceWidth + b]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busFire) begin
            s1Graph <= bus.graph;
            s1Rounds <= bus.rounds;
            s1Partial <= partialNext;
        end
    end

    ////////////////////////////////
    // Stage two, final sum
    ////////////////////////////////

    always_comb begin
        countNext = '0;
        for (int s = 0; s < sliceCount; s++) begin
            countNext = countNext + countWidth'(s1Partial[s]);
        end
    end

    always_ff @(posedge clk) begin
        if (s2Free && s1Valid) begin
            outGraph <= s1Graph;
            outRounds <= s1Rounds;
            outCount <= countNext;
        end
    end

    // Both stages move together whenever the output can take a word
    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            outValid <= 1'b0;
        end else if (s2Free) begin
            s1Valid <= busFire;
            outValid <= s1Valid;
        end
    end

endmodule

// ==== logic/pruneEngine.sv ====
module pruneEngine import leafPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  logic [graphWidth-1:0] inGraph,
    graphBus.source               bus
);

    typedef enum logic [1:0] {
        stateIdle,
        stateDown,
        stateUp,
        stateHold
    } engineState;

    engineState state;

    logic [graphWidth-1:0] workGraph;
    logic [graphWidth-1:0] downIn;
    logic [graphWidth-1:0] downOut;
    logic [graphWidth-1:0] upOut;
    logic [roundWidth-1:0] roundCount;
    logic                  inFire;
    logic                  busFire;
    logic                  roundDone;
    logic                  downEn;
    logic                  upEn;

    ////////////////////////////////
    // Control
    ////////////////////////////////

    assign inReady = (state == stateIdle);
    assign inFire = inValid && inReady;

    // The down state of a later round also checks the round before it.
    // workGraph still holds that round's input, upOut holds its result
    assign roundDone = (state == stateDown) && (roundCount != '0) &&
                       ((upOut == workGraph) || (roundCount == roundWidth'(maxRounds)));

    // First round starts from the accepted graph, later ones from the last result
    assign downIn = (roundCount == '0) ? workGraph : upOut;

    assign downEn = (state == stateDown) && !roundDone;
    assign upEn = (state == stateUp);

    assign bus.valid = roundDone || (state == stateHold);
    assign bus.graph = upOut;
    assign bus.rounds = roundCount;
    assign busFire = bus.valid && bus.ready;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stateIdle;
            roundCount <= '0;
        end else begin
            case (state)
                stateIdle: begin
                    if (inFire) begin
                        state <= stateDown;
                        roundCount <= '0;
                    end
                end
                stateDown: begin
                    if (!roundDone) begin
                        state <= stateUp;
                    end else if (busFire) begin
                        state <= stateIdle;
                    end else begin
                        state <= stateHold;
                    end
                end
                stateUp: begin
                    state <= stateDown;
                    roundCount <= roundCount + roundWidth'(1);
                end
                default: begin
                    // Result waits for the counter
                    if (busFire) begin
                        state <= stateIdle;
                    end
                end
            endcase
        end
    end

    // Round input, replaced by the result when another round is needed
    always_ff @(posedge clk) begin
        if (inFire) begin
            workGraph <= inGraph;
        end else if (downEn && (roundCount != '0)) begin
            workGraph <= upOut;
        end
    end

    ////////////////////////////////
    // Datapath
    ////////////////////////////////

    leafElimination #(
        .direction(directionDown)
    ) downStep (
        .clk(clk),
        .rstN(rstN),
        .clkEn(downEn),
        .graphIn(downIn),
        .graphOut(downOut)
    );

    leafElimination #(
        .direction(directionUp)
    ) upStep (
        .clk(clk),
        .rstN(rstN),
        .clkEn(upEn),
        .graphIn(downOut),
        .graphOut(upOut)
    );

endmodule

// ==== logic/pruneTop.sv ====
module pruneTop import leafPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,

    // Graph in
    input  logic                  inValid,
    output logic                  inReady,
    input  logic [graphWidth-1:0] inGraph,

    // Pruned result out
    output logic                  outValid,
    input  logic                  outReady,
    output logic [graphWidth-1:0] outGraph,
    output logic [countWidth-1:0] outCount,
    output logic [roundWidth-1:0] outRounds
);

    ////////////////////////////////
    // Engine to counter link
    ////////////////////////////////

    graphBus link ();

    ////////////////////////////////
    // Pruning engine
    ////////////////////////////////

    // Busy from acceptance until the counter takes the result
    pruneEngine engine (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inReady(inReady),
        .inGraph(inGraph),
        .bus(link.source)
    );

    ////////////////////////////////
    // Node counter
    ////////////////////////////////

    // Two graphs can sit here, which frees the engine for the next one
    nodeCounter counter (
        .clk(clk),
        .rstN(rstN),
        .bus(link.sink),
        .outValid(outValid),
        .outReady(outReady),
        .outGraph(outGraph),
        .outCount(outCount),
        .outRounds(outRounds)
    );

endmodule

// ==== tb.f ====
logic/leafPkg.sv
logic/graphBus.sv
logic/leafElimination.sv
logic/pruneEngine.sv
logic/nodeCounter.sv
logic/pruneTop.sv
bench/prune_assertions.sv
bench/pruneTb.sv
